// File: core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    localparam int XLEN = 32;

    ////////////////////
    // Branch predictor geometry
    ////////////////////
    localparam int PRED_ENTRIES = 256;
    localparam int PRED_IDX_W   = 8;
    localparam int PRED_IDX_LSB = 2;
    localparam int BTB_TAG_W    = 7;
    localparam int BTB_TAG_LSB  = PRED_IDX_LSB + PRED_IDX_W;
    localparam int BHT_CNT_W    = 2;

    // Strongly not taken
    localparam logic [BHT_CNT_W-1:0] BHT_INIT = 2'b00;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

    ////////////////////
    // Register file and data memory
    ////////////////////
    localparam int RF_DEPTH  = 32;
    localparam int RF_ADDR_W = 5;
    localparam int DM_DEPTH  = 32;
    localparam int DM_ADDR_W = 5;

    function automatic logic [PRED_IDX_W-1:0] pred_idx(input logic [XLEN-1:0] pc);
        return pc[PRED_IDX_LSB +: PRED_IDX_W];
    endfunction

    function automatic logic [BTB_TAG_W-1:0] btb_tag(input logic [XLEN-1:0] pc);
        return pc[BTB_TAG_LSB +: BTB_TAG_W];
    endfunction

endpackage

`default_nettype wire

// File: boot_pkg.sv
`default_nettype none

package boot_pkg;

    typedef enum logic [0:0] {
        SWEEP,
        READY
    } boot_state_t;

    // One sweep cycle per predictor entry since that is the largest array
    localparam int SWEEP_LEN = 256;

    localparam int DM_PRELOAD_LEN = 27;

    // Program data holds a falling ramp, a rising ramp and then a zeroed block
    localparam logic [core_cfg_pkg::XLEN-1:0] DM_PRELOAD [DM_PRELOAD_LEN] = '{
        32'd9, 32'd8, 32'd7, 32'd6, 32'd5, 32'd4, 32'd3, 32'd2, 32'd1,
        32'd1, 32'd2, 32'd3, 32'd4, 32'd5, 32'd6, 32'd7, 32'd8, 32'd9,
        32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0
    };

endpackage

`default_nettype wire

// File: init_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface init_bus_if;

    logic                                busy;
    logic [core_cfg_pkg::PRED_IDX_W-1:0] addr;
    logic                                clr_we;
    logic [core_cfg_pkg::XLEN-1:0]       dm_data;

    modport master
    (
        output busy,
        output addr,
        output clr_we,
        output dm_data
    );

    // Every storage array only listens to the sweep
    modport target
    (
        input busy,
        input addr,
        input clr_we,
        input dm_data
    );

endinterface

`default_nettype wire

// File: init_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module init_sequencer
(
    input  logic              clk,
    input  logic              rst_i,
    init_bus_if.master        bus,
    output logic              ready
);

    boot_pkg::boot_state_t               state_q;
    logic [core_cfg_pkg::PRED_IDX_W-1:0] addr_q;

    ////////////////////
    // Sweep state machine
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            state_q <= boot_pkg::SWEEP;
            addr_q  <= '0;
        end
        else if (state_q == boot_pkg::SWEEP)
        begin
            addr_q <= addr_q + 1'b1;
            // Stop after the last entry instead of wrapping back to zero
            if (addr_q == boot_pkg::SWEEP_LEN - 1)
            begin
                state_q <= boot_pkg::READY;
            end
        end
    end

    assign bus.busy   = (state_q == boot_pkg::SWEEP);
    assign bus.clr_we = (state_q == boot_pkg::SWEEP);
    assign bus.addr   = addr_q;
    assign ready      = (state_q == boot_pkg::READY);

    // Preload word for the low data memory addresses and zero above the table
    always_comb
    begin
        if (addr_q < boot_pkg::DM_PRELOAD_LEN)
        begin
            bus.dm_data = boot_pkg::DM_PRELOAD[addr_q[core_cfg_pkg::DM_ADDR_W-1:0]];
        end
        else
        begin
            bus.dm_data = '0;
        end
    end

endmodule

`default_nettype wire

// File: branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer
(
    input  logic                          clk,
    init_bus_if.target                    bus,
    input  logic [core_cfg_pkg::XLEN-1:0] lookup_pc,
    output logic                          hit,
    output logic [core_cfg_pkg::XLEN-1:0] target,
    input  logic                          upd_valid,
    input  logic [core_cfg_pkg::XLEN-1:0] upd_pc,
    input  logic [core_cfg_pkg::XLEN-1:0] upd_target
);

    core_cfg_pkg::btb_entry_t btb [core_cfg_pkg::PRED_ENTRIES];
    core_cfg_pkg::btb_entry_t lookup_entry;
    core_cfg_pkg::btb_entry_t upd_entry;

    always_comb
    begin
        upd_entry.valid  = 1'b1;
        upd_entry.tag    = core_cfg_pkg::btb_tag(upd_pc);
        upd_entry.target = upd_target;
    end

    ////////////////////
    // Clear on sweep, otherwise overwrite on a resolved branch
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (bus.busy)
        begin
            if (bus.clr_we)
            begin
                btb[bus.addr] <= '0;
            end
        end
        else if (upd_valid)
        begin
            btb[core_cfg_pkg::pred_idx(upd_pc)] <= upd_entry;
        end
    end

    // Fetch-side lookup
    assign lookup_entry = btb[core_cfg_pkg::pred_idx(lookup_pc)];
    assign hit    = lookup_entry.valid &&
                    (lookup_entry.tag == core_cfg_pkg::btb_tag(lookup_pc));
    assign target = lookup_entry.target;

endmodule

`default_nettype wire

// File: branch_history_table.sv
`timescale 1ns/1ps
`default_nettype none

module branch_history_table
(
    input  logic                          clk,
    init_bus_if.target                    bus,
    input  logic [core_cfg_pkg::XLEN-1:0] lookup_pc,
    output logic                          taken,
    input  logic                          upd_valid,
    input  logic [core_cfg_pkg::XLEN-1:0] upd_pc,
    input  logic                          upd_taken
);

    logic [core_cfg_pkg::BHT_CNT_W-1:0] cnt [core_cfg_pkg::PRED_ENTRIES];
    logic [core_cfg_pkg::BHT_CNT_W-1:0] upd_cnt;
    logic [core_cfg_pkg::BHT_CNT_W-1:0] upd_next;

    assign upd_cnt = cnt[core_cfg_pkg::pred_idx(upd_pc)];

    // Saturating step toward the resolved direction
    always_comb
    begin
        upd_next = upd_cnt;
        if (upd_taken && (upd_cnt != '1))
        begin
            upd_next = upd_cnt + 1'b1;
        end
        else if (!upd_taken && (upd_cnt != '0))
        begin
            upd_next = upd_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.busy)
        begin
            if (bus.clr_we)
            begin
                cnt[bus.addr] <= core_cfg_pkg::BHT_INIT;
            end
        end
        else if (upd_valid)
        begin
            cnt[core_cfg_pkg::pred_idx(upd_pc)] <= upd_next;
        end
    end

    // Upper counter bit gives the prediction
    assign taken = cnt[core_cfg_pkg::pred_idx(lookup_pc)][core_cfg_pkg::BHT_CNT_W-1];

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
(
    input  logic                               clk,
    init_bus_if.target                         bus,
    input  logic [core_cfg_pkg::RF_ADDR_W-1:0] raddr_a,
    input  logic [core_cfg_pkg::RF_ADDR_W-1:0] raddr_b,
    output logic [core_cfg_pkg::XLEN-1:0]      rdata_a,
    output logic [core_cfg_pkg::XLEN-1:0]      rdata_b,
    input  logic                               we,
    input  logic [core_cfg_pkg::RF_ADDR_W-1:0] waddr,
    input  logic [core_cfg_pkg::XLEN-1:0]      wdata
);

    logic [core_cfg_pkg::XLEN-1:0] regs [core_cfg_pkg::RF_DEPTH];

    always_ff @(posedge clk)
    begin
        if (bus.busy)
        begin
            if (bus.clr_we && (bus.addr < core_cfg_pkg::RF_DEPTH))
            begin
                regs[bus.addr[core_cfg_pkg::RF_ADDR_W-1:0]] <= '0;
            end
        end
        else if (we && (waddr != '0))
        begin
            regs[waddr] <= wdata;
        end
    end

    // x0 is hardwired to zero
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

endmodule

`default_nettype wire

// File: data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem
(
    input  logic                               clk,
    init_bus_if.target                         bus,
    input  logic [core_cfg_pkg::DM_ADDR_W-1:0] addr,
    output logic [core_cfg_pkg::XLEN-1:0]      rdata,
    input  logic                               we,
    input  logic [core_cfg_pkg::XLEN-1:0]      wdata
);

    logic [core_cfg_pkg::XLEN-1:0] mem [core_cfg_pkg::DM_DEPTH];

    ////////////////////
    // Preload during the sweep, core stores afterwards
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (bus.busy)
        begin
            if (bus.clr_we && (bus.addr < core_cfg_pkg::DM_DEPTH))
            begin
                mem[bus.addr[core_cfg_pkg::DM_ADDR_W-1:0]] <= bus.dm_data;
            end
        end
        else if (we)
        begin
            mem[addr] <= wdata;
        end
    end

    assign rdata = mem[addr];

endmodule

`default_nettype wire

// File: bringup_top.sv
`timescale 1ns/1ps
`default_nettype none

module bringup_top
(
    input  logic                               clk,
    input  logic                               rst_i,
    output logic                               ready,

    input  logic [core_cfg_pkg::XLEN-1:0]      pred_pc,
    output logic                               pred_hit,
    output logic                               pred_taken,
    output logic [core_cfg_pkg::XLEN-1:0]      pred_target,

    input  logic                               upd_valid,
    input  logic [core_cfg_pkg::XLEN-1:0]      upd_pc,
    input  logic                               upd_taken,
    input  logic [core_cfg_pkg::XLEN-1:0]      upd_target,

    input  logic [core_cfg_pkg::RF_ADDR_W-1:0] rf_raddr_a,
    input  logic [core_cfg_pkg::RF_ADDR_W-1:0] rf_raddr_b,
    output logic [core_cfg_pkg::XLEN-1:0]      rf_rdata_a,
    output logic [core_cfg_pkg::XLEN-1:0]      rf_rdata_b,
    input  logic                               rf_we,
    input  logic [core_cfg_pkg::RF_ADDR_W-1:0] rf_waddr,
    input  logic [core_cfg_pkg::XLEN-1:0]      rf_wdata,

    input  logic [core_cfg_pkg::DM_ADDR_W-1:0] dm_addr,
    output logic [core_cfg_pkg::XLEN-1:0]      dm_rdata,
    input  logic                               dm_we,
    input  logic [core_cfg_pkg::XLEN-1:0]      dm_wdata
);

    init_bus_if u_init_bus ();

    init_sequencer u_init_sequencer
    (
        .clk   (clk),
        .rst_i (rst_i),
        .bus   (u_init_bus),
        .ready (ready)
    );

    ////////////////////
    // Branch prediction storage
    ////////////////////
    branch_target_buffer u_btb
    (
        .clk        (clk),
        .bus        (u_init_bus),
        .lookup_pc  (pred_pc),
        .hit        (pred_hit),
        .target     (pred_target),
        .upd_valid  (upd_valid),
        .upd_pc     (upd_pc),
        .upd_target (upd_target)
    );

    branch_history_table u_bht
    (
        .clk       (clk),
        .bus       (u_init_bus),
        .lookup_pc (pred_pc),
        .taken     (pred_taken),
        .upd_valid (upd_valid),
        .upd_pc    (upd_pc),
        .upd_taken (upd_taken)
    );

    ////////////////////
    // Architectural state
    ////////////////////
    reg_file u_reg_file
    (
        .clk     (clk),
        .bus     (u_init_bus),
        .raddr_a (rf_raddr_a),
        .raddr_b (rf_raddr_b),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata)
    );

    data_mem u_data_mem
    (
        .clk   (clk),
        .bus   (u_init_bus),
        .addr  (dm_addr),
        .rdata (dm_rdata),
        .we    (dm_we),
        .wdata (dm_wdata)
    );

endmodule

`default_nettype wire

// File: tb_bringup.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bringup;

    localparam int NUM_UPDATES  = 50;
    localparam int NUM_WRITES   = 200;
    localparam int SWEEP_CYCLES = 2 * (6 + boot_pkg::SWEEP_LEN);
    localparam int TEST_CYCLES  = 2 * core_cfg_pkg::PRED_ENTRIES + 3 * NUM_UPDATES
                                  + 2 * NUM_WRITES;
    localparam int MAX_CYCLES   = 2 * (SWEEP_CYCLES + TEST_CYCLES);

    logic        clk = 1'b0;
    logic        rst_i;
    logic        ready;
    logic [31:0] pred_pc;
    logic        pred_hit;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        upd_valid;
    logic [31:0] upd_pc;
    logic        upd_taken;
    logic [31:0] upd_target;
    logic [4:0]  rf_raddr_a;
    logic [4:0]  rf_raddr_b;
    logic [31:0] rf_rdata_a;
    logic [31:0] rf_rdata_b;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;
    logic [4:0]  dm_addr;
    logic [31:0] dm_rdata;
    logic        dm_we;
    logic [31:0] dm_wdata;

    logic        chk;
    string       test_name;
    int          check_errors = 0;
    int          seq_errors = 0;
    int          cycles = 0;
    logic [31:0] lfsr_state;

    // Reference state of every storage array
    logic        btb_valid_m  [core_cfg_pkg::PRED_ENTRIES];
    logic [6:0]  btb_tag_m    [core_cfg_pkg::PRED_ENTRIES];
    logic [31:0] btb_target_m [core_cfg_pkg::PRED_ENTRIES];
    logic [1:0]  bht_m        [core_cfg_pkg::PRED_ENTRIES];
    logic [31:0] rf_m         [core_cfg_pkg::RF_DEPTH];
    logic [31:0] dm_m         [core_cfg_pkg::DM_DEPTH];

    bringup_top u_bringup_top
    (
        .clk         (clk),
        .rst_i       (rst_i),
        .ready       (ready),
        .pred_pc     (pred_pc),
        .pred_hit    (pred_hit),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .upd_valid   (upd_valid),
        .upd_pc      (upd_pc),
        .upd_taken   (upd_taken),
        .upd_target  (upd_target),
        .rf_raddr_a  (rf_raddr_a),
        .rf_raddr_b  (rf_raddr_b),
        .rf_rdata_a  (rf_rdata_a),
        .rf_rdata_b  (rf_rdata_b),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .dm_addr     (dm_addr),
        .dm_rdata    (dm_rdata),
        .dm_we       (dm_we),
        .dm_wdata    (dm_wdata)
    );

    always #10 clk = ~clk;

    ////////////////////
    // Random source and reference functions
    ////////////////////
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          k;
        v = '0;
        for (k = 0; k < n; k++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic logic lookup_hits(input logic [31:0] pc);
        return btb_valid_m[pc[9:2]] && (btb_tag_m[pc[9:2]] == pc[16:10]);
    endfunction

    function automatic logic predicts_taken(input logic [31:0] pc);
        return bht_m[pc[9:2]][1];
    endfunction

    function automatic logic [1:0] bht_step(input logic [1:0] cnt, input logic taken);
        if (taken)
        begin
            return (cnt == 2'd3) ? cnt : cnt + 2'd1;
        end
        return (cnt == 2'd0) ? cnt : cnt - 2'd1;
    endfunction

    function automatic logic [31:0] reg_read_ref(input logic [4:0] a);
        return (a == 5'd0) ? 32'd0 : rf_m[a];
    endfunction

    task automatic reset_models();
        int i;
        for (i = 0; i < core_cfg_pkg::PRED_ENTRIES; i++)
        begin
            btb_valid_m[i]  = 1'b0;
            btb_tag_m[i]    = '0;
            btb_target_m[i] = '0;
            bht_m[i]        = core_cfg_pkg::BHT_INIT;
        end
        for (i = 0; i < core_cfg_pkg::RF_DEPTH; i++)
        begin
            rf_m[i] = '0;
        end
        for (i = 0; i < core_cfg_pkg::DM_DEPTH; i++)
        begin
            dm_m[i] = (i < boot_pkg::DM_PRELOAD_LEN) ? boot_pkg::DM_PRELOAD[i] : '0;
        end
    endtask

    ////////////////////
    // Stimulus helpers
    ////////////////////
    task automatic idle_strobes();
        rf_we     <= 1'b0;
        dm_we     <= 1'b0;
        upd_valid <= 1'b0;
    endtask

    // Random writes and updates that the sweep must drop
    task automatic drive_noise();
        logic [31:0] r;
        r = rand_bits(11);
        rf_we     <= 1'b1;
        rf_waddr  <= r[4:0];
        dm_we     <= 1'b1;
        dm_addr   <= r[9:5];
        upd_valid <= 1'b1;
        upd_taken <= r[10];
        rf_wdata  <= rand_bits(32);
        dm_wdata  <= rand_bits(32);
        upd_pc    <= rand_bits(32);
        upd_target <= rand_bits(32);
    endtask

    task automatic apply_reset(input logic noisy);
        int i;
        rst_i <= 1'b1;
        for (i = 0; i < 5; i++)
        begin
            @(posedge clk);
            if (i == 4)
            begin
                rst_i <= 1'b0;
            end
            if (noisy)
            begin
                drive_noise();
            end
            else
            begin
                idle_strobes();
            end
            @(negedge clk);
            if (ready !== 1'b0)
            begin
                seq_errors++;
                $display("ready was not low during reset");
            end
        end
    endtask

    // Counts edges with rst_i low until ready shows up
    task automatic run_sweep(input logic noisy);
        int n;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
            if (noisy && (n < boot_pkg::SWEEP_LEN - 8))
            begin
                drive_noise();
            end
            else
            begin
                idle_strobes();
            end
            @(negedge clk);
        end
        while (!ready && (n < boot_pkg::SWEEP_LEN + 16));
        if (n != boot_pkg::SWEEP_LEN)
        begin
            seq_errors++;
            $display("ready rose after %0d cycles instead of %0d", n, boot_pkg::SWEEP_LEN);
        end
    endtask

    task automatic check_initial(input string name);
        logic [31:0] r;
        int          i;
        for (i = 0; i < core_cfg_pkg::PRED_ENTRIES; i++)
        begin
            @(posedge clk);
            r = rand_bits(22);
            test_name = name;
            pred_pc    <= {r[21:7], r[6:0], i[7:0], 2'b00};
            rf_raddr_a <= i[4:0];
            rf_raddr_b <= ~i[4:0];
            dm_addr    <= i[4:0];
            chk        <= 1'b1;
        end
    endtask

    // Two indices and two tags with taken and not-taken runs of ten
    task automatic predictor_updates();
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] tgt;
        logic        taken;
        int          i;
        for (i = 0; i < NUM_UPDATES; i++)
        begin
            @(posedge clk);
            r = rand_bits(17);
            pc = {r[16:2], 6'd0, r[1], 7'd0, r[0], 2'b00};
            tgt = rand_bits(32);
            taken = ((i / 10) % 2) == 0;
            upd_valid  <= 1'b1;
            upd_pc     <= pc;
            upd_taken  <= taken;
            upd_target <= tgt;
            chk        <= 1'b0;
            @(posedge clk);
            btb_valid_m[pc[9:2]]  = 1'b1;
            btb_tag_m[pc[9:2]]    = pc[16:10];
            btb_target_m[pc[9:2]] = tgt;
            bht_m[pc[9:2]]        = bht_step(bht_m[pc[9:2]], taken);
            test_name = "predict";
            upd_valid <= 1'b0;
            pred_pc   <= pc;
            chk       <= 1'b1;
            @(posedge clk);
            test_name = "btb_tag_miss";
            pred_pc <= pc ^ 32'h0000_0400;
        end
    endtask

    task automatic reg_mem_writes();
        logic [31:0] r;
        logic [31:0] wd;
        logic [31:0] dd;
        int          i;
        for (i = 0; i < NUM_WRITES; i++)
        begin
            @(posedge clk);
            r = rand_bits(15);
            wd = rand_bits(32);
            dd = rand_bits(32);
            rf_we    <= 1'b1;
            rf_waddr <= r[4:0];
            rf_wdata <= wd;
            dm_we    <= 1'b1;
            dm_addr  <= r[9:5];
            dm_wdata <= dd;
            chk      <= 1'b0;
            @(posedge clk);
            if (r[4:0] != 5'd0)
            begin
                rf_m[r[4:0]] = wd;
            end
            dm_m[r[9:5]] = dd;
            test_name = "rf_dm";
            rf_we      <= 1'b0;
            dm_we      <= 1'b0;
            rf_raddr_a <= r[4:0];
            rf_raddr_b <= r[14:10];
            chk        <= 1'b1;
        end
    endtask

    ////////////////////
    // Output comparison on the falling edge
    ////////////////////
    always @(negedge clk)
    begin
        if (chk)
        begin
            if (ready !== 1'b1)
            begin
                check_errors++;
                $display("ready dropped during %s", test_name);
            end
            if (pred_hit !== lookup_hits(pred_pc))
            begin
                check_errors++;
                $display("ERROR %s: pred_hit expected %0b actual %0b",
                         test_name, lookup_hits(pred_pc), pred_hit);
            end
            if (lookup_hits(pred_pc) && (pred_target !== btb_target_m[pred_pc[9:2]]))
            begin
                check_errors++;
                $display("ERROR %s: pred_target expected %08h actual %08h",
                         test_name, btb_target_m[pred_pc[9:2]], pred_target);
            end
            if (pred_taken !== predicts_taken(pred_pc))
            begin
                check_errors++;
                $display("ERROR %s: pred_taken expected %0b actual %0b",
                         test_name, predicts_taken(pred_pc), pred_taken);
            end
            if (rf_rdata_a !== reg_read_ref(rf_raddr_a))
            begin
                check_errors++;
                $display("ERROR %s: rf_rdata_a expected %08h actual %08h",
                         test_name, reg_read_ref(rf_raddr_a), rf_rdata_a);
            end
            if (rf_rdata_b !== reg_read_ref(rf_raddr_b))
            begin
                check_errors++;
                $display("ERROR %s: rf_rdata_b expected %08h actual %08h",
                         test_name, reg_read_ref(rf_raddr_b), rf_rdata_b);
            end
            if (dm_rdata !== dm_m[dm_addr])
            begin
                check_errors++;
                $display("ERROR %s: dm_rdata expected %08h actual %08h",
                         test_name, dm_m[dm_addr], dm_rdata);
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Run timed out after %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        lfsr_state = 32'h433a_bf9b;
        rst_i      = 1'b1;
        pred_pc    = '0;
        upd_valid  = 1'b0;
        upd_pc     = '0;
        upd_taken  = 1'b0;
        upd_target = '0;
        rf_raddr_a = '0;
        rf_raddr_b = '0;
        rf_we      = 1'b0;
        rf_waddr   = '0;
        rf_wdata   = '0;
        dm_addr    = '0;
        dm_we      = 1'b0;
        dm_wdata   = '0;
        chk        = 1'b0;
        test_name  = "reset";
        reset_models();

        apply_reset(1'b0);
        run_sweep(1'b0);
        check_initial("after_boot");
        predictor_updates();
        reg_mem_writes();

        // Second boot with traffic on every write port
        @(posedge clk);
        chk <= 1'b0;
        apply_reset(1'b1);
        reset_models();
        run_sweep(1'b1);
        check_initial("after_reboot");
        @(posedge clk);
        chk <= 1'b0;

        $display("Errors: %0d value, %0d sequence", check_errors, seq_errors);
        if ((check_errors == 0) && (seq_errors == 0))
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
core_cfg_pkg.sv
boot_pkg.sv
init_bus_if.sv
init_sequencer.sv
branch_target_buffer.sv
branch_history_table.sv
reg_file.sv
data_mem.sv
bringup_top.sv
tb_bringup.sv

// File: Bender.yml
package:
  name: bringup

sources:
  - core_cfg_pkg.sv
  - boot_pkg.sv
  - init_bus_if.sv
  - init_sequencer.sv
  - branch_target_buffer.sv
  - branch_history_table.sv
  - reg_file.sv
  - data_mem.sv
  - bringup_top.sv
  - target: test
    files:
      - tb_bringup.sv
